// File: compile.f
src/cpu_pkg.sv
src/instr_issue.sv
src/memory_pipeline_unit.sv
src/memory_controller.sv
src/memory_unit.sv
verif/memory_unit_checker.sv
verif/tb_memory_unit.sv

// File: Makefile
# Verilator build and run for the memory unit testbench

VERILATOR ?= verilator
TOP       ?= tb_memory_unit
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Simulation passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) --binary --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "FAILED: see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verif/memory_unit_testdata.txt
# name instr status stall valid gap expect
# expect bits: 14 bref, 13:12 sel_pc, 11 load_pc, 10 br_imm, 9 A, 8 B, 7:5 alu, 4 pre, 3 S, 1 w_en1, 0 mem_w
add_imm    e0012003 00000000 0 1 0 0b02
sub_reg_s  e3312004 00000000 0 1 0 082a
sub_alt    e0412005 00000000 0 1 0 0b22
and_op     e1612006 00000000 0 1 0 0942
orr_op     e2812007 00000000 0 1 0 0a62
xor_op     e0a12008 00000000 0 1 0 0be2
cmp_s      e1512000 00000000 0 1 0 0928
add_dflt   e0c12009 00000000 0 1 0 0b02
ldr_pre_wb ec012e04 00000000 0 1 0 0902
str_post   ee012004 00000000 0 1 0 0931
ldr_reg    ed012805 00000000 0 1 0 0820
ldr_alt    e8012606 00000000 0 1 0 0910
str_pre_s  ef112c00 00000000 0 1 0 0809
br_eq      09000010 40000000 0 1 2 3d00
br_ne      19000010 40000000 0 1 2 4d00
br_cs      29000010 20000000 0 1 2 7d00
br_cc      39000010 20000000 0 1 2 0d00
br_mi      49000010 80000000 0 1 2 3d00
br_pl      59000010 80000000 0 1 2 4d00
br_vs      69000010 10000000 0 1 2 7d00
br_vc      79000010 00000000 0 1 2 3d00
br_hi      89000010 20000000 0 1 2 7d00
br_ls      99000010 20000000 0 1 2 0d00
br_ge      a9000010 90000000 0 1 2 3d00
br_lt      b9000010 80000000 0 1 2 7d00
br_gt      c9000010 40000000 0 1 2 0d00
br_le      d9000010 00000000 0 1 2 0d00
br_al      e9000010 00000000 0 1 2 3d00
sq_branch  e9000010 00000000 0 1 0 7d00
sq_first   e0012003 00000000 0 1 0 0000
sq_second  e0a12008 00000000 0 1 0 0000
sq_third   e0012003 00000000 0 1 0 0b02
st_held    e0a12008 00000000 0 1 0 0be2
st_next    e1612006 00000000 0 1 0 0942
st_drop_a  e0012003 00000000 1 1 0 0000
st_drop_b  e2812007 00000000 1 1 0 0000
st_drop_c  e1512000 00000000 1 1 0 0000
st_after   e0412005 00000000 0 1 0 0b22

// File: verif/tb_memory_unit.sv
module tb_memory_unit;
    import cpu_pkg::*;

    localparam string DATA_FILE   = "verif/memory_unit_testdata.txt";
    localparam int    DRAIN_LIMIT = 50;

    logic        clk;
    logic        rst_n;
    logic [31:0] instr_in;
    logic        instr_valid;
    logic        sel_stall;
    logic [31:0] status_reg;
    logic [3:0]  cond;
    logic [6:0]  opcode;
    logic        en_status;
    logic [3:0]  rd;
    logic [1:0]  shift_op;
    logic [11:0] imm12;
    logic [31:0] imm_branch;
    logic [31:0] instr_output;
    logic [1:0]  sel_pc;
    logic        load_pc;
    logic        sel_branch_imm;
    logic        sel_A;
    logic        sel_B;
    alu_op_e     alu_op;
    logic        sel_pre_indexed;
    logic        en_status_out;
    logic        sel_load_lr;
    logic        w_en1;
    logic        mem_w_en;
    logic        branch_ref_global;

    logic [15:0] ctrl_word;
    logic [95:0] drv_name;
    logic [15:0] drv_expect;
    int          pass_count;
    int          fail_count;
    logic        busy;

    // fields of one data line
    logic [95:0] f_name;
    logic [31:0] f_instr;
    logic [31:0] f_status;
    logic        f_stall;
    logic        f_valid;
    int          f_gap;
    logic [15:0] f_expect;
    string       line;
    int          fd;
    int          fields;
    int          wait_cycles;
    logic        data_ok;

    initial clk = 1'b0;
    always #4 clk = ~clk;

    assign ctrl_word = {1'b0, branch_ref_global, sel_pc, load_pc, sel_branch_imm, sel_A,
                        sel_B, alu_op, sel_pre_indexed, en_status_out, sel_load_lr,
                        w_en1, mem_w_en};

    memory_unit u_memory_unit (
        .clk(clk), .rst_n(rst_n), .instr_in(instr_in), .instr_valid(instr_valid),
        .sel_stall(sel_stall), .status_reg(status_reg), .cond(cond), .opcode(opcode),
        .en_status(en_status), .rd(rd), .shift_op(shift_op), .imm12(imm12),
        .imm_branch(imm_branch), .instr_output(instr_output), .sel_pc(sel_pc),
        .load_pc(load_pc), .sel_branch_imm(sel_branch_imm), .sel_A(sel_A), .sel_B(sel_B),
        .alu_op(alu_op), .sel_pre_indexed(sel_pre_indexed), .en_status_out(en_status_out),
        .sel_load_lr(sel_load_lr), .w_en1(w_en1), .mem_w_en(mem_w_en),
        .branch_ref_global(branch_ref_global)
    );

    memory_unit_checker u_checker (
        .clk(clk), .rst_n(rst_n), .drv_valid(instr_valid), .drv_stall(sel_stall),
        .drv_name(drv_name), .drv_instr(instr_in), .drv_expect(drv_expect),
        .ctrl_word(ctrl_word), .cond(cond), .opcode(opcode), .en_status(en_status),
        .rd(rd), .shift_op(shift_op), .imm12(imm12), .imm_branch(imm_branch),
        .instr_output(instr_output), .pass_count(pass_count), .fail_count(fail_count),
        .busy(busy)
    );

    // one data line, then its idle cycles with the same status word
    task automatic apply_line;
        @(negedge clk);
        instr_in    = f_instr;
        status_reg  = f_status;
        sel_stall   = f_stall;
        instr_valid = f_valid;
        drv_name    = f_name;
        drv_expect  = f_expect;
        for (int i = 0; i < f_gap; i++) begin
            @(negedge clk);
            instr_valid = 1'b0;
            sel_stall   = 1'b0;
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        instr_in    = 32'h0;
        instr_valid = 1'b0;
        sel_stall   = 1'b0;
        status_reg  = 32'h0;
        drv_name    = '0;
        drv_expect  = 16'h0;
        data_ok     = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            $display("could not open the test data file %0s", DATA_FILE);
            data_ok = 1'b0;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 3 && line.getc(0) != "#") begin
                    fields = $sscanf(line, "%s %h %h %h %h %d %h", f_name, f_instr,
                                     f_status, f_stall, f_valid, f_gap, f_expect);
                    if (fields != 7) begin
                        $display("badly formed line in the test data file: %0s", line);
                        data_ok = 1'b0;
                    end else begin
                        apply_line();
                    end
                end
            end
            $fclose(fd);
        end
        @(negedge clk);
        instr_valid = 1'b0;
        sel_stall   = 1'b0;
        wait_cycles = 0;
        while (busy && wait_cycles < DRAIN_LIMIT) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (busy) begin
            $display("timed out waiting for the last tests to leave the pipeline");
            $display("Simulation failed");
        end else begin
            $display("tests %0d, passed %0d, failed %0d",
                     pass_count + fail_count, pass_count, fail_count);
            if (data_ok && fail_count == 0 && pass_count > 1) begin
                $display("Simulation passed");
            end else begin
                $display("Simulation failed");
            end
        end
        $finish;
    end

endmodule : tb_memory_unit

// File: verif/memory_unit_checker.sv
module memory_unit_checker (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        drv_valid,
    input  logic        drv_stall,
    input  logic [95:0] drv_name,
    input  logic [31:0] drv_instr,
    input  logic [15:0] drv_expect,
    input  logic [15:0] ctrl_word,
    input  logic [3:0]  cond,
    input  logic [6:0]  opcode,
    input  logic        en_status,
    input  logic [3:0]  rd,
    input  logic [1:0]  shift_op,
    input  logic [11:0] imm12,
    input  logic [31:0] imm_branch,
    input  logic [31:0] instr_output,
    output int          pass_count,
    output int          fail_count,
    output logic        busy
);

    // shadow of the two pipeline slots
    logic        issue_vld;
    logic [95:0] issue_name;
    logic [31:0] issue_word;
    logic [15:0] issue_exp;
    logic        stage_vld;
    logic [95:0] stage_name;
    logic [31:0] stage_word;
    logic [15:0] stage_exp;
    logic        stage_bad;
    logic        reset_seen;
    logic        squash;
    logic [93:0] field_view;

    // tests strobed under stall, watched until they could have reached the stage
    logic [95:0] drop_name[$];
    logic [31:0] drop_word[$];
    int          drop_left[$];
    logic        drop_bad[$];

    assign field_view = {instr_output, cond, opcode, en_status, rd, shift_op, imm12,
                         imm_branch};

    // held word and its fields as the instruction format defines them
    function automatic logic [93:0] expected_view(input logic [31:0] w);
        logic [31:0] offset;
        offset = {{20{w[11]}}, w[11:0]} << 2;
        return {w, w[31:28], w[27:21], w[20], w[15:12], w[6:5], w[11:0], offset};
    endfunction

    task automatic finish_test(input logic [95:0] name, input logic bad);
        if (bad) begin
            $display("fail %0s", name);
            fail_count++;
        end else begin
            $display("pass %0s", name);
            pass_count++;
        end
    endtask

    // sampled on the rising edge, before the DUT registers update
    always @(posedge clk) begin
        if (!rst_n) begin
            issue_vld  = 1'b0;
            stage_vld  = 1'b0;
            stage_bad  = 1'b0;
            reset_seen = 1'b0;
            busy       = 1'b0;
            pass_count = 0;
            fail_count = 0;
            drop_name.delete();
            drop_word.delete();
            drop_left.delete();
            drop_bad.delete();
        end else begin
            if (!reset_seen) begin
                reset_seen = 1'b1;
                if (ctrl_word != 16'h0000 ||
                    field_view != expected_view({4'b1111, 28'd0})) begin
                    $display("mismatch reset_state: expected %h/%h, actual %h/%h",
                             16'h0000, expected_view({4'b1111, 28'd0}),
                             ctrl_word, field_view);
                    finish_test("reset_state", 1'b1);
                end else begin
                    finish_test("reset_state", 1'b0);
                end
            end
            // also repeated on every stalled cycle
            if (stage_vld && ctrl_word != stage_exp) begin
                $display("mismatch %0s: expected %h, actual %h",
                         stage_name, stage_exp, ctrl_word);
                stage_bad = 1'b1;
            end
            if (stage_vld && field_view != expected_view(stage_word)) begin
                $display("mismatch %0s fields: expected %h, actual %h",
                         stage_name, expected_view(stage_word), field_view);
                stage_bad = 1'b1;
            end
            for (int i = 0; i < drop_word.size(); i++) begin
                if (instr_output == drop_word[i]) begin
                    $display("test %0s was strobed under stall but reached the stage",
                             drop_name[i]);
                    drop_bad[i] = 1'b1;
                end
            end
            if (!drv_stall) begin
                // a taken branch squashes the entry in issue and the one strobed now
                squash = stage_vld && stage_exp[13:12] == 2'b11;
                if (stage_vld) begin
                    finish_test(stage_name, stage_bad);
                end
                stage_vld  = issue_vld;
                stage_name = issue_name;
                stage_word = squash ? {4'b1111, 28'd0} : issue_word;
                stage_exp  = issue_exp;
                stage_bad  = 1'b0;
                issue_vld  = drv_valid;
                issue_name = drv_name;
                issue_word = squash ? {4'b1111, 28'd0} : drv_instr;
                issue_exp  = drv_expect;
                for (int i = 0; i < drop_left.size(); i++) begin
                    drop_left[i]--;
                end
                while (drop_left.size() != 0 && drop_left[0] == 0) begin
                    finish_test(drop_name[0], drop_bad[0]);
                    drop_name.delete(0);
                    drop_word.delete(0);
                    drop_left.delete(0);
                    drop_bad.delete(0);
                end
            end else if (drv_valid) begin
                drop_name.push_back(drv_name);
                drop_word.push_back(drv_instr);
                drop_left.push_back(2);
                drop_bad.push_back(1'b0);
            end
            busy = issue_vld || stage_vld || (drop_name.size() != 0);
        end
    end

endmodule : memory_unit_checker

// File: src/memory_unit.sv
module memory_unit (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [31:0]       instr_in,
    input  logic              instr_valid,
    input  logic              sel_stall,
    input  logic [31:0]       status_reg,
    // decoded fields
    output logic [3:0]        cond,
    output logic [6:0]        opcode,
    output logic              en_status,
    output logic [3:0]        rd,
    output logic [1:0]        shift_op,
    output logic [11:0]       imm12,
    output logic [31:0]       imm_branch,
    output logic [31:0]       instr_output,
    // datapath controls
    output logic [1:0]        sel_pc,
    output logic              load_pc,
    output logic              sel_branch_imm,
    output logic              sel_A,
    output logic              sel_B,
    output cpu_pkg::alu_op_e  alu_op,
    output logic              sel_pre_indexed,
    output logic              en_status_out,
    output logic              sel_load_lr,
    output logic              w_en1,
    output logic              mem_w_en,
    output logic              branch_ref_global
);

    logic [31:0] issue_instr;
    logic        issue_valid;
    logic        issue_tag;
    logic        p_bit;
    logic        u_bit;
    logic        w_bit;

    instr_issue u_issue (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_in    (instr_in),
        .instr_valid (instr_valid),
        .sel_stall   (sel_stall),
        .branch_ref  (branch_ref_global),
        .issue_instr (issue_instr),
        .issue_valid (issue_valid),
        .issue_tag   (issue_tag)
    );

    memory_pipeline_unit u_stage (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_instr  (issue_instr),
        .issue_valid  (issue_valid),
        .issue_tag    (issue_tag),
        .branch_ref   (branch_ref_global),
        .sel_stall    (sel_stall),
        .cond         (cond),
        .opcode       (opcode),
        .en_status    (en_status),
        .rd           (rd),
        .shift_op     (shift_op),
        .imm12        (imm12),
        .imm_branch   (imm_branch),
        .P            (p_bit),
        .U            (u_bit),
        .W            (w_bit),
        .instr_output (instr_output)
    );

    memory_controller u_ctrl (
        .clk               (clk),
        .rst_n             (rst_n),
        .cond              (cond),
        .opcode            (opcode),
        .en_status         (en_status),
        .P                 (p_bit),
        .U                 (u_bit),
        .W                 (w_bit),
        .status_reg        (status_reg),
        .sel_stall         (sel_stall),
        .sel_pc            (sel_pc),
        .load_pc           (load_pc),
        .sel_branch_imm    (sel_branch_imm),
        .sel_A             (sel_A),
        .sel_B             (sel_B),
        .alu_op            (alu_op),
        .sel_pre_indexed   (sel_pre_indexed),
        .en_status_out     (en_status_out),
        .sel_load_lr       (sel_load_lr),
        .w_en1             (w_en1),
        .mem_w_en          (mem_w_en),
        .branch_ref_global (branch_ref_global)
    );

endmodule : memory_unit

// File: src/memory_controller.sv
module memory_controller (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [3:0]        cond,
    input  logic [6:0]        opcode,
    input  logic              en_status,
    input  logic              P,
    input  logic              U,
    input  logic              W,
    input  logic [31:0]       status_reg,
    input  logic              sel_stall,
    output logic [1:0]        sel_pc,
    output logic              load_pc,
    output logic              sel_branch_imm,
    output logic              sel_A,
    output logic              sel_B,
    output cpu_pkg::alu_op_e  alu_op,
    output logic              sel_pre_indexed,
    output logic              en_status_out,
    output logic              sel_load_lr,
    output logic              w_en1,
    output logic              mem_w_en,
    output logic              branch_ref_global
);
    import cpu_pkg::*;

    op_class_e op_class;
    logic      flag_n;
    logic      flag_z;
    logic      flag_c;
    logic      flag_v;
    logic      cond_pass;
    logic      branch_taken;

    assign flag_n = status_reg[FLAG_N];
    assign flag_z = status_reg[FLAG_Z];
    assign flag_c = status_reg[FLAG_C];
    assign flag_v = status_reg[FLAG_V];

    // class from opcode, bubbles fall to none
    always_comb begin
        if (cond == COND_NV) begin
            op_class = CLS_NONE;
        end else if (!opcode[6] && opcode[5:4] != 2'b10) begin
            op_class = CLS_DATA;
        end else if (opcode[6:5] == 2'b11 || opcode[6:3] == 4'b1000) begin
            op_class = CLS_MEM;
        end else if (opcode[6:3] == 4'b1001) begin
            op_class = CLS_BRANCH;
        end else begin
            op_class = CLS_NONE;
        end
    end

    always_comb begin
        case (cond)
            COND_EQ: cond_pass = flag_z;
            COND_NE: cond_pass = !flag_z;
            COND_CS: cond_pass = flag_c;
            COND_CC: cond_pass = !flag_c;
            COND_MI: cond_pass = flag_n;
            COND_PL: cond_pass = !flag_n;
            COND_VS: cond_pass = flag_v;
            COND_VC: cond_pass = !flag_v;
            COND_HI: cond_pass = flag_c && !flag_z;
            COND_LS: cond_pass = !flag_c || flag_z;
            COND_GE: cond_pass = (flag_n == flag_v);
            COND_LT: cond_pass = (flag_n != flag_v);
            COND_GT: cond_pass = !flag_z && (flag_n == flag_v);
            COND_LE: cond_pass = flag_z || (flag_n != flag_v);
            COND_AL: cond_pass = 1'b1;
            default: cond_pass = 1'b0;
        endcase
    end

    assign branch_taken = (op_class == CLS_BRANCH) && cond_pass;

    always_comb begin
        sel_pc          = 2'b00;
        load_pc         = 1'b0;
        sel_branch_imm  = 1'b0;
        sel_A           = 1'b0;
        sel_B           = 1'b0;
        alu_op          = ALU_ADD;
        sel_pre_indexed = 1'b0;
        en_status_out   = 1'b0;
        sel_load_lr     = 1'b0;
        w_en1           = 1'b0;
        mem_w_en        = 1'b0;
        case (op_class)
            CLS_DATA: begin
                load_pc       = 1'b1;
                sel_A         = !opcode[3];
                sel_B         = !opcode[4];
                en_status_out = en_status;
                w_en1         = (opcode[3:0] != OPC_CMP);
                case (opcode[2:0])
                    3'b001:  alu_op = ALU_SUB;
                    3'b010:  alu_op = ALU_SUB;
                    3'b011:  alu_op = ALU_AND;
                    3'b100:  alu_op = ALU_ORR;
                    3'b101:  alu_op = ALU_XOR;
                    default: alu_op = ALU_ADD;
                endcase
            end
            CLS_MEM: begin
                load_pc         = 1'b1;
                // base always from rn
                sel_B           = !opcode[3];
                sel_pre_indexed = !P;
                alu_op          = U ? ALU_ADD : ALU_SUB;
                en_status_out   = en_status;
                w_en1           = P && W;
                mem_w_en        = opcode[4];
            end
            CLS_BRANCH: begin
                load_pc        = 1'b1;
                sel_pc         = branch_taken ? 2'b11 : 2'b00;
                // bit 1 set means target from register
                sel_A          = opcode[1];
                sel_B          = !opcode[1];
                sel_branch_imm = !opcode[1];
                // link write
                w_en1          = opcode[2];
            end
            default: begin
            end
        endcase
    end

    // flips once per taken branch, held while stalled
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            branch_ref_global <= 1'b0;
        end else if (!sel_stall && branch_taken) begin
            branch_ref_global <= !branch_ref_global;
        end
    end

endmodule : memory_controller

// File: src/memory_pipeline_unit.sv
module memory_pipeline_unit (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] issue_instr,
    input  logic        issue_valid,
    input  logic        issue_tag,
    input  logic        branch_ref,
    input  logic        sel_stall,
    output logic [3:0]  cond,
    output logic [6:0]  opcode,
    output logic        en_status,
    output logic [3:0]  rd,
    output logic [1:0]  shift_op,
    output logic [11:0] imm12,
    output logic [31:0] imm_branch,
    output logic        P,
    output logic        U,
    output logic        W,
    output logic [31:0] instr_output
);
    import cpu_pkg::*;

    logic [31:0] stage_instr;
    logic        stage_tag;
    logic        drop_in;
    logic [31:0] held_word;

    // invalid or already stale on the way in
    assign drop_in = !issue_valid || (issue_tag != branch_ref);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage_instr <= BUBBLE_INSTR;
            stage_tag   <= 1'b0;
        end else if (!sel_stall) begin
            stage_instr <= drop_in ? BUBBLE_INSTR : issue_instr;
            stage_tag   <= issue_tag;
        end
    end

    // entry held while a branch toggled the reference goes stale here
    assign held_word = (stage_tag == branch_ref) ? stage_instr : BUBBLE_INSTR;

    assign instr_output = held_word;

    // field split
    assign cond      = held_word[INSTR_COND_LSB +: 4];
    assign opcode    = held_word[INSTR_OPC_LSB +: 7];
    assign en_status = held_word[INSTR_S_BIT];
    assign rd        = held_word[INSTR_RD_LSB +: 4];
    assign imm12     = held_word[INSTR_IMM_LSB +: 12];
    assign shift_op  = imm12[IMM_SHIFT_LSB +: 2];

    // addressing mode bits, memory ops only
    assign P = imm12[IMM_P_BIT];
    assign U = imm12[IMM_U_BIT];
    assign W = imm12[IMM_W_BIT];

    // word offset, sign extended
    assign imm_branch = {{18{imm12[11]}}, imm12, 2'b00};

endmodule : memory_pipeline_unit

// File: src/instr_issue.sv
module instr_issue (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] instr_in,
    input  logic        instr_valid,
    input  logic        sel_stall,
    input  logic        branch_ref,
    output logic [31:0] issue_instr,
    output logic        issue_valid,
    output logic        issue_tag
);
    import cpu_pkg::*;

    // no strobe this cycle, hold a bubble
    logic [31:0] next_instr;

    assign next_instr = instr_valid ? instr_in : BUBBLE_INSTR;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issue_instr <= BUBBLE_INSTR;
            issue_valid <= 1'b0;
            issue_tag   <= 1'b0;
        end else if (!sel_stall) begin
            issue_instr <= next_instr;
            issue_valid <= instr_valid;
            // tag with the reference seen at capture
            issue_tag   <= branch_ref;
        end
    end

endmodule : instr_issue

// File: src/cpu_pkg.sv
package cpu_pkg;

    // instruction word layout
    localparam int INSTR_COND_LSB = 28;
    localparam int INSTR_OPC_LSB  = 21;
    localparam int INSTR_S_BIT    = 20;
    localparam int INSTR_RD_LSB   = 12;
    localparam int INSTR_IMM_LSB  = 0;

    // sub-fields inside imm12
    localparam int IMM_SHIFT_LSB = 5;
    localparam int IMM_P_BIT     = 11;
    localparam int IMM_U_BIT     = 10;
    localparam int IMM_W_BIT     = 9;

    // condition codes
    localparam logic [3:0] COND_EQ = 4'b0000;
    localparam logic [3:0] COND_NE = 4'b0001;
    localparam logic [3:0] COND_CS = 4'b0010;
    localparam logic [3:0] COND_CC = 4'b0011;
    localparam logic [3:0] COND_MI = 4'b0100;
    localparam logic [3:0] COND_PL = 4'b0101;
    localparam logic [3:0] COND_VS = 4'b0110;
    localparam logic [3:0] COND_VC = 4'b0111;
    localparam logic [3:0] COND_HI = 4'b1000;
    localparam logic [3:0] COND_LS = 4'b1001;
    localparam logic [3:0] COND_GE = 4'b1010;
    localparam logic [3:0] COND_LT = 4'b1011;
    localparam logic [3:0] COND_GT = 4'b1100;
    localparam logic [3:0] COND_LE = 4'b1101;
    localparam logic [3:0] COND_AL = 4'b1110;
    localparam logic [3:0] COND_NV = 4'b1111;

    // a bubble is cond NV with every other field zero
    localparam logic [31:0] BUBBLE_INSTR = {COND_NV, 28'd0};

    typedef enum logic [2:0] {
        ALU_ADD = 3'b000,
        ALU_SUB = 3'b001,
        ALU_AND = 3'b010,
        ALU_ORR = 3'b011,
        ALU_XOR = 3'b111
    } alu_op_e;

    typedef enum logic [1:0] {
        CLS_NONE   = 2'b00,
        CLS_DATA   = 2'b01,
        CLS_MEM    = 2'b10,
        CLS_BRANCH = 2'b11
    } op_class_e;

    // compare, no register write
    localparam logic [3:0] OPC_CMP = 4'b1010;

    // status word flag positions
    localparam int FLAG_N = 31;
    localparam int FLAG_Z = 30;
    localparam int FLAG_C = 29;
    localparam int FLAG_V = 28;

endpackage : cpu_pkg
